// File: Makefile
TOP := cgra_acc_tb

.PHONY: all lint clean

all:
	verilator --binary --assert -j 0 -f list.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: bench/cgra_acc_properties.sv
`timescale 1ns/1ps

module cgra_acc_properties (
  input logic               clk,
  input logic               arst_n,
  input cgra_pkg::ch_mask_t available_read,
  input cgra_pkg::ch_mask_t request_read,
  input cgra_pkg::ch_mask_t read_data_valid,
  input cgra_pkg::ch_mask_t available_write,
  input cgra_pkg::ch_mask_t request_write
);

  import cgra_pkg::*;

  int       avail_fails = 0;
  int       order_fails = 0;
  int       pulse_fails = 0;
  int       violations;
  ch_mask_t waiting_q;

  assign violations = avail_fails + order_fails + pulse_fails;

  // Channels with a read in flight
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) waiting_q <= '0;
    else         waiting_q <= (waiting_q & ~read_data_valid) | request_read;
  end

  // ==============================
  // Memory side strobes
  // ==============================
  req_needs_avail: assert property (@(posedge clk) disable iff (!arst_n)
    ((request_read & ~available_read) | (request_write & ~available_write)) == '0)
  else begin
    avail_fails++;
    $error("request without its available level");
  end

  one_read_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
    (request_read & waiting_q) == '0)
  else begin
    order_fails++;
    $error("second read request before the answer");
  end

  single_cycle_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    ((request_read & $past(request_read)) | (request_write & $past(request_write))) == '0)
  else begin
    pulse_fails++;
    $error("request held longer than one cycle");
  end

endmodule

bind cgra_acc cgra_acc_properties cgra_acc_properties_inst (
  .clk(clk),
  .arst_n(arst_n),
  .available_read(available_read),
  .request_read(request_read),
  .read_data_valid(read_data_valid),
  .available_write(available_write),
  .request_write(request_write)
);

// File: bench/cgra_acc_tb.sv
`timescale 1ns/1ps

module cgra_acc_tb;

  import cgra_pkg::*;

  localparam int FIFO_DEPTH = 8;
  localparam int TIMEOUT    = 20000;

  logic                    clk;
  logic                    arst_n;
  logic                    start;
  ch_mask_t                done_rd_data;
  ch_mask_t                done_wr_data;
  ch_mask_t                available_read;
  ch_mask_t                request_read;
  ch_mask_t                read_data_valid;
  data_line_t [NUM_CH-1:0] read_data;
  ch_mask_t                available_write;
  ch_mask_t                request_write;
  data_line_t [NUM_CH-1:0] write_data;
  logic                    acc_done;

  // Memory model state
  logic [15:0] lfsr_q;
  data_line_t  rd_q      [NUM_CH][$];
  data_line_t  exp_q     [NUM_CH][$];
  int          rd_left   [NUM_CH];
  int          wait_cnt  [NUM_CH];
  int          stall_cnt [NUM_CH];
  ch_mask_t    rd_mask;
  ch_mask_t    rd_seen;
  ch_mask_t    wr_seen;
  logic        conf_pending;
  logic        start_pulse;

  cgra_acc #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) cgra_acc_inst (
    .clk(clk),
    .arst_n(arst_n),
    .start(start),
    .done_rd_data(done_rd_data),
    .done_wr_data(done_wr_data),
    .available_read(available_read),
    .request_read(request_read),
    .read_data_valid(read_data_valid),
    .read_data(read_data),
    .available_write(available_write),
    .request_write(request_write),
    .write_data(write_data),
    .acc_done(acc_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==============================
  // Failure reporting and checks
  // ==============================
  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_run(input string why);
    $display("%s (at %0t ns)", why, $time);
    stop_run();
  endtask

  task automatic check_line(input string name, input data_line_t got, input data_line_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_mask(input string name, input ch_mask_t got, input ch_mask_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Galois LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
  function automatic int take_bits(input int n);
    int   value;
    logic out_bit;
    value = 0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr_q[0];
      lfsr_q  = {1'b0, lfsr_q[15:1]} ^ (out_bit ? 16'hB400 : 16'h0000);
      value   = (value << 1) | int'(out_bit);
    end
    return value;
  endfunction

  function automatic data_line_t rand_line();
    data_line_t line;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      line[i*WORD_W +: WORD_W] = WORD_W'(take_bits(WORD_W));
    end
    return line;
  endfunction

  // Reference PE rule modulo 2^16 with a zero-extended operand
  function automatic data_line_t transform(input data_line_t line, input pe_conf_t conf);
    data_line_t res;
    data_word_t w;
    data_word_t operand;
    operand = {{(WORD_W-OPERAND_W){1'b0}}, conf.operand};
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      w = line[i*WORD_W +: WORD_W];
      case (conf.opcode)
        op_add:  w = w + operand;
        op_sub:  w = w - operand;
        op_xor:  w = w ^ operand;
        default: w = w;
      endcase
      res[i*WORD_W +: WORD_W] = w;
    end
    return res;
  endfunction

  // ==============================
  // Memory side model
  // ==============================
  task automatic drive_memory();
    start       = start_pulse;
    start_pulse = 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      read_data_valid[ch] = 1'b0;
      if (wait_cnt[ch] == 0) begin
        read_data_valid[ch] = 1'b1;
        read_data[ch]       = rd_q[ch].pop_front();
        if (ch == 0) conf_pending = 1'b0;
      end
      if (wait_cnt[ch] >= 0) wait_cnt[ch]--;
      // Masked channels go quiet once every line has been asked for
      available_read[ch] = (take_bits(2) != 0) && (!rd_mask[ch] || rd_left[ch] > 0);
      if (stall_cnt[ch] > 0) begin
        stall_cnt[ch]--;
        available_write[ch] = 1'b0;
      end else if (take_bits(4) == 0) begin
        stall_cnt[ch]       = 12 + take_bits(4);
        available_write[ch] = 1'b0;
      end else begin
        available_write[ch] = (take_bits(1) == 1);
      end
      done_rd_data[ch] = (rd_q[ch].size() == 0);
      done_wr_data[ch] = (exp_q[ch].size() == 0);
    end
  endtask

  task automatic sample_outputs();
    if (cgra_acc_inst.cgra_acc_properties_inst.violations != 0) begin
      fail_run("a bound assertion on the memory strobes failed");
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (request_read[ch]) begin
        check_flag($sformatf("available_read[%0d]", ch), available_read[ch], 1'b1);
        if (wait_cnt[ch] >= 0) fail_run($sformatf("channel %0d asked again too early", ch));
        if (ch != 0 && conf_pending) begin
          fail_run($sformatf("channel %0d requested before the configuration line", ch));
        end
        if (rd_left[ch] == 0) fail_run($sformatf("unexpected read request on channel %0d", ch));
        if (!conf_pending) rd_seen[ch] = 1'b1;
        rd_left[ch]--;
        wait_cnt[ch] = take_bits(2);
      end
      if (request_write[ch]) begin
        check_flag($sformatf("available_write[%0d]", ch), available_write[ch], 1'b1);
        if (exp_q[ch].size() == 0) fail_run($sformatf("unexpected write on channel %0d", ch));
        check_line($sformatf("write_data[%0d]", ch), write_data[ch], exp_q[ch].pop_front());
        wr_seen[ch] = 1'b1;
      end
    end
  endtask

  // Outputs are stable between the falling and the next rising edge
  task automatic step_cycle();
    @(negedge clk);
    drive_memory();
    #1;
    sample_outputs();
  endtask

  task automatic wait_acc_done(input logic level);
    int cycles;
    cycles = 0;
    while (acc_done !== level) begin
      step_cycle();
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run($sformatf("timeout waiting for acc_done to become %0b", level));
      end
    end
  endtask

  // ==============================
  // One accelerator run
  // ==============================
  task automatic run_test(input ch_mask_t rmask, input ch_mask_t wmask,
                          input pe_conf_t [NUM_CH-1:0] confs);
    conf_line_t conf;
    data_line_t line;
    int         n_lines;
    conf.read_mask  = rmask;
    conf.write_mask = wmask;
    conf.pe_conf    = confs;
    rd_mask         = rmask;
    rd_seen         = '0;
    wr_seen         = '0;
    conf_pending    = 1'b1;
    rd_q[0].push_back(data_line_t'(conf));
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (rmask[ch]) begin
        n_lines = 2 + take_bits(3);
        repeat (n_lines) begin
          line = rand_line();
          rd_q[ch].push_back(line);
          if (wmask[ch]) exp_q[ch].push_back(transform(line, confs[ch]));
        end
      end
      rd_left[ch] = rd_q[ch].size();
    end
    start_pulse = 1'b1;
    step_cycle();
    wait_acc_done(1'b0);
    wait_acc_done(1'b1);
    check_mask("done_wr_data", done_wr_data, '1);
    check_mask("done_rd_data", done_rd_data, '1);
    check_mask("channels reading", rd_seen, rmask);
    check_mask("channels writing", wr_seen, rmask & wmask);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_flag($sformatf("lines missing on channel %0d", ch), exp_q[ch].size() != 0, 1'b0);
    end
  endtask

  initial begin
    pe_conf_t [NUM_CH-1:0] confs;
    ch_mask_t              rmask;
    ch_mask_t              wmask;
    lfsr_q          = 16'd46005;
    arst_n          = 1'b0;
    start           = 1'b0;
    start_pulse     = 1'b0;
    conf_pending    = 1'b0;
    done_rd_data    = '0;
    done_wr_data    = '0;
    available_read  = '0;
    read_data_valid = '0;
    read_data       = '0;
    available_write = '0;
    rd_mask         = '0;
    rd_seen         = '0;
    wr_seen         = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      rd_left[ch]   = 0;
      wait_cnt[ch]  = -1;
      stall_cnt[ch] = 0;
    end
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    // Quiet until start
    repeat (8) begin
      step_cycle();
      check_mask("request_read", request_read, '0);
      check_mask("request_write", request_write, '0);
      check_flag("acc_done", acc_done, 1'b0);
    end

    // All channels with PE n running opcode n
    for (int ch = 0; ch < NUM_CH; ch++) begin
      confs[ch].opcode  = pe_op_t'(ch);
      confs[ch].operand = OPERAND_W'(take_bits(OPERAND_W));
    end
    run_test('1, '1, confs);

    // Second run with random masks and opcodes
    for (int ch = 0; ch < NUM_CH; ch++) begin
      confs[ch].opcode  = pe_op_t'(take_bits(2));
      confs[ch].operand = OPERAND_W'(take_bits(OPERAND_W));
    end
    rmask = ch_mask_t'(take_bits(NUM_CH)) | ch_mask_t'(1 << take_bits(2));
    wmask = rmask | ch_mask_t'(take_bits(NUM_CH));
    run_test(rmask, wmask, confs);

    if (cgra_acc_inst.cgra_acc_properties_inst.violations == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_run("bound assertions reported violations");
    end
  end

endmodule

// File: design/cgra_acc.sv
`timescale 1ns/1ps

module cgra_acc #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        start,
  input  cgra_pkg::ch_mask_t                          done_rd_data,
  input  cgra_pkg::ch_mask_t                          done_wr_data,
  input  cgra_pkg::ch_mask_t                          available_read,
  output cgra_pkg::ch_mask_t                          request_read,
  input  cgra_pkg::ch_mask_t                          read_data_valid,
  input  cgra_pkg::data_line_t [cgra_pkg::NUM_CH-1:0] read_data,
  input  cgra_pkg::ch_mask_t                          available_write,
  output cgra_pkg::ch_mask_t                          request_write,
  output cgra_pkg::data_line_t [cgra_pkg::NUM_CH-1:0] write_data,
  output logic                                        acc_done
);

  import cgra_pkg::*;

  ch_mask_t                fetch_req;
  ch_mask_t                dispatch_req;
  logic                    conf_req;
  logic                    conf_done;
  ch_mask_t                read_fifo_mask;
  ch_mask_t                write_fifo_mask;
  pe_conf_t   [NUM_CH-1:0] pe_conf;
  ch_mask_t                en_fetch_data;
  logic                    en_pe;
  ch_mask_t                fifo_in_pop;
  ch_mask_t                avail_pop;
  data_word_t [NUM_CH-1:0] fifo_in_data;
  ch_mask_t                fifo_out_push;
  ch_mask_t                avail_push;
  data_word_t [NUM_CH-1:0] fifo_out_data;
  ch_mask_t                pe_busy;
  ch_mask_t                fetch_idle;
  ch_mask_t                dispatch_idle;

  // Configuration read shares channel 0
  assign request_read  = (fetch_req & read_fifo_mask) | {{(NUM_CH-1){1'b0}}, conf_req};
  assign request_write = dispatch_req & write_fifo_mask;

  // ==============================
  // Memory side arrays
  // ==============================
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : gen_channel
    fetch_data #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) fetch_data (
      .clk(clk),
      .arst_n(arst_n),
      .en(en_fetch_data[ch]),
      .available_read(available_read[ch]),
      .request_read(fetch_req[ch]),
      .read_data_valid(read_data_valid[ch]),
      .read_data(read_data[ch]),
      .pop(fifo_in_pop[ch]),
      .avail_pop(avail_pop[ch]),
      .data_out(fifo_in_data[ch]),
      .idle(fetch_idle[ch])
    );

    dispatch_data #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) dispatch_data (
      .clk(clk),
      .arst_n(arst_n),
      .available_write(available_write[ch]),
      .request_write(dispatch_req[ch]),
      .write_data(write_data[ch]),
      .push(fifo_out_push[ch]),
      .avail_push(avail_push[ch]),
      .data_in(fifo_out_data[ch]),
      .idle(dispatch_idle[ch])
    );
  end

  control_conf control_conf (
    .clk(clk),
    .arst_n(arst_n),
    .start(start),
    .available_read(available_read[0]),
    .req_rd_data(conf_req),
    .rd_data(read_data[0]),
    .rd_data_valid(read_data_valid[0]),
    .read_fifo_mask(read_fifo_mask),
    .write_fifo_mask(write_fifo_mask),
    .pe_conf(pe_conf),
    .done(conf_done)
  );

  control_exec control_exec (
    .clk(clk),
    .arst_n(arst_n),
    .start(conf_done),
    .read_fifo_mask(read_fifo_mask),
    .write_fifo_mask(write_fifo_mask),
    .fetch_idle(fetch_idle),
    .dispatch_idle(dispatch_idle),
    .pe_busy(pe_busy),
    .read_fifo_done(done_rd_data),
    .write_fifo_done(done_wr_data),
    .en_fetch_data(en_fetch_data),
    .en_pe(en_pe),
    .done(acc_done)
  );

  pe_array pe_array (
    .clk(clk),
    .arst_n(arst_n),
    .en(en_pe),
    .pe_conf(pe_conf),
    .avail_pop(avail_pop),
    .pop(fifo_in_pop),
    .fifo_in_data(fifo_in_data),
    .avail_push(avail_push),
    .push(fifo_out_push),
    .fifo_out_data(fifo_out_data),
    .pe_busy(pe_busy)
  );

endmodule

// File: design/cgra_pkg.sv
package cgra_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int NUM_CH         = 4;
  localparam int WORD_W         = 16;
  localparam int LINE_W         = 64;
  localparam int WORDS_PER_LINE = 4;
  localparam int OPERAND_W      = 12;

  typedef logic [WORD_W-1:0] data_word_t;

  // Word 0 sits in the low bits
  typedef logic [LINE_W-1:0] data_line_t;

  typedef logic [NUM_CH-1:0] ch_mask_t;

  // ==============================
  // PE configuration
  // ==============================
  typedef enum logic [1:0] {
    op_pass = 2'd0,
    op_add  = 2'd1,
    op_sub  = 2'd2,
    op_xor  = 2'd3
  } pe_op_t;

  typedef struct packed {
    pe_op_t                opcode;
    logic [OPERAND_W-1:0]  operand;
  } pe_conf_t;

  // Exactly one memory line with PE 0 in the lowest bits
  typedef struct packed {
    ch_mask_t                read_mask;
    ch_mask_t                write_mask;
    pe_conf_t [NUM_CH-1:0]   pe_conf;
  } conf_line_t;

endpackage

// File: design/control_conf.sv
`timescale 1ns/1ps

module control_conf (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      start,
  input  logic                                      available_read,
  output logic                                      req_rd_data,
  input  cgra_pkg::data_line_t                      rd_data,
  input  logic                                      rd_data_valid,
  output cgra_pkg::ch_mask_t                        read_fifo_mask,
  output cgra_pkg::ch_mask_t                        write_fifo_mask,
  output cgra_pkg::pe_conf_t [cgra_pkg::NUM_CH-1:0] pe_conf,
  output logic                                      done
);

  import cgra_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait
  } conf_state_t;

  conf_state_t state_q;
  conf_line_t  conf_q;
  logic        conf_arrived;

  assign req_rd_data     = (state_q == st_request) & available_read;
  assign conf_arrived    = (state_q == st_wait) & rd_data_valid;
  assign read_fifo_mask  = conf_q.read_mask;
  assign write_fifo_mask = conf_q.write_mask;
  assign pe_conf         = conf_q.pe_conf;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      conf_q  <= '0;
      done    <= 1'b0;
    end else begin
      done <= conf_arrived;
      case (state_q)
        st_idle: begin
          // Old masks go away so nothing runs during the reload
          if (start) begin
            conf_q  <= '0;
            state_q <= st_request;
          end
        end
        st_request: if (req_rd_data) state_q <= st_wait;
        st_wait: begin
          if (conf_arrived) begin
            conf_q  <= conf_line_t'(rd_data);
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

// File: design/control_exec.sv
`timescale 1ns/1ps

module control_exec (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  input  cgra_pkg::ch_mask_t read_fifo_mask,
  input  cgra_pkg::ch_mask_t write_fifo_mask,
  input  cgra_pkg::ch_mask_t fetch_idle,
  input  cgra_pkg::ch_mask_t dispatch_idle,
  input  cgra_pkg::ch_mask_t pe_busy,
  input  cgra_pkg::ch_mask_t read_fifo_done,
  input  cgra_pkg::ch_mask_t write_fifo_done,
  output cgra_pkg::ch_mask_t en_fetch_data,
  output logic               en_pe,
  output logic               done
);

  import cgra_pkg::*;

  ch_mask_t rd_ch_ok;
  ch_mask_t wr_ch_ok;
  logic     finished;

  // ==============================
  // Completion rule
  // ==============================
  // Unused channels count as finished
  assign rd_ch_ok = ~read_fifo_mask | (read_fifo_done & fetch_idle);
  assign wr_ch_ok = ~write_fifo_mask | (write_fifo_done & dispatch_idle);
  assign finished = en_pe & (&rd_ch_ok) & (&wr_ch_ok) & ~(|pe_busy);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      en_fetch_data <= '0;
      en_pe         <= 1'b0;
      done          <= 1'b0;
    end else if (start) begin
      en_fetch_data <= read_fifo_mask;
      en_pe         <= 1'b1;
      done          <= 1'b0;
    end else if (finished) begin
      en_fetch_data <= '0;
      en_pe         <= 1'b0;
      done          <= 1'b1;
    end
  end

endmodule

// File: design/dispatch_data.sv
`timescale 1ns/1ps

module dispatch_data #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 available_write,
  output logic                 request_write,
  output cgra_pkg::data_line_t write_data,
  input  logic                 push,
  output logic                 avail_push,
  input  cgra_pkg::data_word_t data_in,
  output logic                 idle
);

  import cgra_pkg::*;

  localparam int CNT_W = $clog2(WORDS_PER_LINE);

  data_word_t       fifo_data;
  logic             fifo_empty;
  logic             fifo_full;
  logic             fifo_pop;
  data_line_t       line_q;
  logic [CNT_W-1:0] word_cnt_q;
  logic             pending_q;

  // Assembly stops while a full line waits for the write port
  assign fifo_pop      = ~pending_q & ~fifo_empty;
  assign avail_push    = ~fifo_full;
  assign request_write = pending_q & available_write;
  assign write_data    = line_q;
  assign idle          = fifo_empty & ~pending_q & (word_cnt_q == '0);

  always_ff @(posedge clk) begin
    if (fifo_pop) line_q[word_cnt_q*WORD_W +: WORD_W] <= fifo_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_cnt_q <= '0;
      pending_q  <= 1'b0;
    end else if (fifo_pop) begin
      word_cnt_q <= word_cnt_q + 1'b1;
      if (word_cnt_q == CNT_W'(WORDS_PER_LINE - 1)) pending_q <= 1'b1;
    end else if (request_write) begin
      pending_q <= 1'b0;
    end
  end

  word_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .item_t(data_word_t)
  ) word_fifo (
    .clk(clk),
    .arst_n(arst_n),
    .push(push),
    .push_data(data_in),
    .pop(fifo_pop),
    .pop_data(fifo_data),
    .empty(fifo_empty),
    .full(fifo_full),
    .free_count()
  );

endmodule

// File: design/fetch_data.sv
`timescale 1ns/1ps

module fetch_data #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 en,
  input  logic                 available_read,
  output logic                 request_read,
  input  logic                 read_data_valid,
  input  cgra_pkg::data_line_t read_data,
  input  logic                 pop,
  output logic                 avail_pop,
  output cgra_pkg::data_word_t data_out,
  output logic                 idle
);

  import cgra_pkg::*;

  localparam int CNT_W = $clog2(WORDS_PER_LINE);

  data_line_t                      line_q;
  logic [CNT_W-1:0]                word_cnt_q;
  logic                            outstanding_q;
  logic                            unpacking_q;
  logic                            fifo_empty;
  logic [$clog2(FIFO_DEPTH+1)-1:0] free_count;
  logic                            room;
  logic                            line_arrived;

  // A whole line must fit before asking for it
  assign room         = (free_count >= WORDS_PER_LINE);
  assign request_read = en & available_read & room & ~outstanding_q & ~unpacking_q;
  // Channel 0 also sees the configuration answer, so only take our own
  assign line_arrived = read_data_valid & outstanding_q;
  assign avail_pop    = ~fifo_empty;
  assign idle         = fifo_empty & ~unpacking_q & ~outstanding_q;

  always_ff @(posedge clk) begin
    if (line_arrived) line_q <= read_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding_q <= 1'b0;
      unpacking_q   <= 1'b0;
      word_cnt_q    <= '0;
    end else begin
      if (request_read) outstanding_q <= 1'b1;
      if (line_arrived) begin
        outstanding_q <= 1'b0;
        unpacking_q   <= 1'b1;
        word_cnt_q    <= '0;
      end else if (unpacking_q) begin
        word_cnt_q <= word_cnt_q + 1'b1;
        if (word_cnt_q == CNT_W'(WORDS_PER_LINE - 1)) unpacking_q <= 1'b0;
      end
    end
  end

  word_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .item_t(data_word_t)
  ) word_fifo (
    .clk(clk),
    .arst_n(arst_n),
    .push(unpacking_q),
    .push_data(line_q[word_cnt_q*WORD_W +: WORD_W]),
    .pop(pop),
    .pop_data(data_out),
    .empty(fifo_empty),
    .full(),
    .free_count(free_count)
  );

endmodule

// File: design/pe_array.sv
`timescale 1ns/1ps

module pe_array (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        en,
  input  cgra_pkg::pe_conf_t   [cgra_pkg::NUM_CH-1:0] pe_conf,
  input  cgra_pkg::ch_mask_t                          avail_pop,
  output cgra_pkg::ch_mask_t                          pop,
  input  cgra_pkg::data_word_t [cgra_pkg::NUM_CH-1:0] fifo_in_data,
  input  cgra_pkg::ch_mask_t                          avail_push,
  output cgra_pkg::ch_mask_t                          push,
  output cgra_pkg::data_word_t [cgra_pkg::NUM_CH-1:0] fifo_out_data,
  output cgra_pkg::ch_mask_t                          pe_busy
);

  import cgra_pkg::*;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : gen_pe
    logic       valid_q;
    data_word_t data_q;
    data_word_t operand;
    data_word_t result;

    assign operand = data_word_t'(pe_conf[ch].operand);

    always_comb begin
      case (pe_conf[ch].opcode)
        op_add:  result = fifo_in_data[ch] + operand;
        op_sub:  result = fifo_in_data[ch] - operand;
        op_xor:  result = fifo_in_data[ch] ^ operand;
        default: result = fifo_in_data[ch];
      endcase
    end

    // A word in the stage takes the last free slot we know of
    assign pop[ch]           = en & avail_pop[ch] & avail_push[ch] & ~valid_q;
    assign push[ch]          = valid_q;
    assign fifo_out_data[ch] = data_q;
    assign pe_busy[ch]       = valid_q;

    always_ff @(posedge clk) begin
      if (pop[ch]) data_q <= result;
    end

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) valid_q <= 1'b0;
      else         valid_q <= pop[ch];
    end
  end

endmodule

// File: design/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
  parameter int  FIFO_DEPTH = 8,
  parameter type item_t     = logic
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              push,
  input  item_t                             push_data,
  input  logic                              pop,
  output item_t                             pop_data,
  output logic                              empty,
  output logic                              full,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]   free_count
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  item_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign do_push    = push & ~full;
  assign do_pop     = pop & ~empty;
  assign empty      = (count_q == '0);
  assign full       = (count_q == CNT_W'(FIFO_DEPTH));
  assign free_count = CNT_W'(FIFO_DEPTH) - count_q;
  // Show-ahead read
  assign pop_data   = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr_q] <= push_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: list.f
design/cgra_pkg.sv
design/word_fifo.sv
design/fetch_data.sv
design/dispatch_data.sv
design/control_conf.sv
design/control_exec.sv
design/pe_array.sv
design/cgra_acc.sv
bench/cgra_acc_properties.sv
bench/cgra_acc_tb.sv
